//--- filelist.f
+incdir+hdl
hdl/alexnet_layer_pkg.sv
hdl/ram_port_pkg.sv
hdl/word_stream_if.sv
hdl/load_sequencer.sv
hdl/fm_loader.sv
hdl/weight_packer.sv
hdl/pcie_controller.sv
tests/pcie_controller_checker.sv
tests/pcie_controller_tb.sv

//--- hdl/alexnet_layer_pkg.sv
`default_nettype none

`include "loader_settings.svh"

package alexnet_layer_pkg;

    typedef enum logic [3:0] {
        IDLE  = 4'd0,
        CONV1, POOL1,
        CONV2, POOL2,
        CONV3, CONV4, CONV5, POOL5,
        FC6, FC7,
        FC8   = 4'd11
    } layer_t;

    typedef logic [3:0] depth_t;   // rows per kernel

    function automatic logic is_conv(layer_t layer);
        return layer inside {CONV1, CONV2, CONV3, CONV4, CONV5};
    endfunction

    // pool and fc layers take no kernels
    function automatic depth_t kernel_depth(layer_t layer);
        case (layer)
            CONV1:   return depth_t'(`CONV1_DEPTH);
            CONV2:   return depth_t'(`CONV2_DEPTH);
            CONV3:   return depth_t'(`CONV3_DEPTH);
            CONV4:   return depth_t'(`CONV4_DEPTH);
            CONV5:   return depth_t'(`CONV5_DEPTH);
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hdl/fm_loader.sv
`default_nettype none

`include "loader_settings.svh"

module fm_loader (
    input  wire                         clk,
    input  wire                         pcieRst,
    word_stream_if.sink                 fm_stream,
    output logic                        layer_write_en,
    output ram_port_pkg::layer_addr_t   layer_write_addr,
    output ram_port_pkg::data_word_t    layer_write_data
);
    import ram_port_pkg::*;

    layer_addr_t fm_count;    // next write address
    logic        accept;

    assign accept = fm_stream.valid && fm_stream.ready;
    assign fm_stream.ready = fm_stream.busy && !fm_stream.finish;

    always_ff @(posedge clk or posedge pcieRst) begin
        if (pcieRst) begin
            fm_count         <= '0;
            layer_write_en   <= 1'b0;
            fm_stream.finish <= 1'b0;
        end else begin
            layer_write_en <= accept;
            if (!fm_stream.busy) begin
                fm_count         <= '0;
                fm_stream.finish <= 1'b0;
            end else if (accept) begin
                fm_count <= fm_count + 1'b1;
                if (fm_count == layer_addr_t'(`FM_WORDS - 1))
                    fm_stream.finish <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            layer_write_addr <= fm_count;
            layer_write_data <= fm_stream.data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/load_sequencer.sv
`default_nettype none

module load_sequencer (
    input  wire                         clk,
    input  wire                         pcieRst,
    input  wire alexnet_layer_pkg::layer_t run_layer,
    input  wire                         load_fm,
    input  wire                         update_weight,
    input  wire                         update_bias,
    input  wire ram_port_pkg::bias_addr_t update_bias_addr,
    input  wire                         host_valid,
    output logic                        host_ready,
    input  wire ram_port_pkg::data_word_t host_data,
    word_stream_if.source               fm_stream,
    word_stream_if.source               weight_stream,
    output alexnet_layer_pkg::layer_t   current_layer,
    output logic                        pcie_data_ready,
    output logic                        update_weight_done,
    output logic                        update_bias_done,
    output logic                        bias_write_en,
    output ram_port_pkg::bias_addr_t    bias_write_addr,
    output ram_port_pkg::data_word_t    bias_write_data
);
    import alexnet_layer_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_FM,
        S_WEIGHT,
        S_BIAS
    } seq_state_t;

    seq_state_t state;
    logic       layer_change;
    logic       bias_ready;

    assign layer_change = run_layer != current_layer;

    ////////////////////////////////////////
    // host stream routing

    assign fm_stream.busy  = state == S_FM;
    assign fm_stream.valid = host_valid && state == S_FM;
    assign fm_stream.data  = host_data;

    assign weight_stream.busy  = state == S_WEIGHT;
    assign weight_stream.valid = host_valid && state == S_WEIGHT;
    assign weight_stream.data  = host_data;

    assign bias_ready = state == S_BIAS && !bias_write_en;    // single word
    assign host_ready = fm_stream.ready || weight_stream.ready || bias_ready;

    ////////////////////////////////////////
    // layer tracking and job selection

    always_ff @(posedge clk or posedge pcieRst) begin
        if (pcieRst) begin
            current_layer <= IDLE;
        end else begin
            current_layer <= run_layer;
        end
    end

    always_ff @(posedge clk or posedge pcieRst) begin
        if (pcieRst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (current_layer == IDLE && load_fm && !pcie_data_ready)
                        state <= S_FM;
                    else if (is_conv(current_layer) && update_weight && !update_weight_done)
                        state <= S_WEIGHT;
                    else if (is_conv(current_layer) && update_bias && !update_bias_done)
                        state <= S_BIAS;
                end
                S_FM:     if (fm_stream.finish) state <= S_IDLE;
                S_WEIGHT: if (weight_stream.finish) state <= S_IDLE;
                S_BIAS:   if (bias_write_en) state <= S_IDLE;    // write cycle ends it
                default:  state <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // bias write and status flags

    always_ff @(posedge clk or posedge pcieRst) begin
        if (pcieRst) begin
            bias_write_en <= 1'b0;
        end else begin
            bias_write_en <= bias_ready && host_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (bias_ready && host_valid) begin
            bias_write_addr <= update_bias_addr;
            bias_write_data <= host_data;
        end
    end

    always_ff @(posedge clk or posedge pcieRst) begin
        if (pcieRst) begin
            pcie_data_ready    <= 1'b0;
            update_weight_done <= 1'b0;
            update_bias_done   <= 1'b0;
        end else begin
            if (state == S_FM && fm_stream.finish)
                pcie_data_ready <= 1'b1;    // held until reset

            if (layer_change || !update_weight)
                update_weight_done <= 1'b0;
            else if (state == S_WEIGHT && weight_stream.finish)
                update_weight_done <= 1'b1;

            if (layer_change || !update_bias)
                update_bias_done <= 1'b0;
            else if (bias_write_en)
                update_bias_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/loader_settings.svh
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// host word and ram geometry
`define WORD_BITS        16
`define FM_WORDS         16
`define KERNEL_TAPS      9    // 3x3 kernel
`define LAYER_ADDR_BITS  19
`define WEIGHT_ADDR_BITS 10
`define BIAS_ADDR_BITS   9

// kernel depth per conv layer scaled down from alexnet
`define CONV1_DEPTH 3
`define CONV2_DEPTH 2
`define CONV3_DEPTH 2
`define CONV4_DEPTH 3
`define CONV5_DEPTH 2

`endif

//--- hdl/pcie_controller.sv
`default_nettype none

module pcie_controller (
    input  wire                            clk,
    input  wire                            pcieRst,
    input  wire alexnet_layer_pkg::layer_t run_layer,
    input  wire                            load_fm,
    input  wire                            update_weight,
    input  wire ram_port_pkg::weight_addr_t update_weight_addr,
    input  wire                            update_bias,
    input  wire ram_port_pkg::bias_addr_t  update_bias_addr,
    input  wire                            host_valid,
    output logic                           host_ready,
    input  wire ram_port_pkg::data_word_t  host_data,
    output logic                           pcie_data_ready,
    output logic                           update_weight_done,
    output logic                           update_bias_done,
    output logic                           layer_write_en,
    output ram_port_pkg::layer_addr_t      layer_write_addr,
    output ram_port_pkg::data_word_t       layer_write_data,
    output logic                           weight_write_en,
    output ram_port_pkg::weight_addr_t     weight_write_addr,
    output ram_port_pkg::weight_row_t      weight_write_data,
    output logic                           bias_write_en,
    output ram_port_pkg::bias_addr_t       bias_write_addr,
    output ram_port_pkg::data_word_t       bias_write_data
);
    import alexnet_layer_pkg::*;

    layer_t current_layer;

    word_stream_if fm_stream ();
    word_stream_if weight_stream ();

    load_sequencer u_load_sequencer (
        .clk                (clk),
        .pcieRst            (pcieRst),
        .run_layer          (run_layer),
        .load_fm            (load_fm),
        .update_weight      (update_weight),
        .update_bias        (update_bias),
        .update_bias_addr   (update_bias_addr),
        .host_valid         (host_valid),
        .host_ready         (host_ready),
        .host_data          (host_data),
        .fm_stream          (fm_stream.source),
        .weight_stream      (weight_stream.source),
        .current_layer      (current_layer),
        .pcie_data_ready    (pcie_data_ready),
        .update_weight_done (update_weight_done),
        .update_bias_done   (update_bias_done),
        .bias_write_en      (bias_write_en),
        .bias_write_addr    (bias_write_addr),
        .bias_write_data    (bias_write_data)
    );

    fm_loader u_fm_loader (
        .clk              (clk),
        .pcieRst          (pcieRst),
        .fm_stream        (fm_stream.sink),
        .layer_write_en   (layer_write_en),
        .layer_write_addr (layer_write_addr),
        .layer_write_data (layer_write_data)
    );

    weight_packer u_weight_packer (
        .clk                (clk),
        .pcieRst            (pcieRst),
        .current_layer      (current_layer),
        .update_weight_addr (update_weight_addr),
        .weight_stream      (weight_stream.sink),
        .weight_write_en    (weight_write_en),
        .weight_write_addr  (weight_write_addr),
        .weight_write_data  (weight_write_data)
    );

endmodule

`default_nettype wire

//--- hdl/ram_port_pkg.sv
`default_nettype none

`include "loader_settings.svh"

package ram_port_pkg;

    typedef logic [`WORD_BITS-1:0] data_word_t;

    // ram address widths
    typedef logic [`LAYER_ADDR_BITS-1:0]  layer_addr_t;
    typedef logic [`WEIGHT_ADDR_BITS-1:0] weight_addr_t;
    typedef logic [`BIAS_ADDR_BITS-1:0]   bias_addr_t;

    // one kernel row with tap 0 in the low word
    typedef logic [`KERNEL_TAPS*`WORD_BITS-1:0] weight_row_t;

endpackage

`default_nettype wire

//--- hdl/weight_packer.sv
`default_nettype none

`include "loader_settings.svh"

module weight_packer (
    input  wire                           clk,
    input  wire                           pcieRst,
    input  wire alexnet_layer_pkg::layer_t current_layer,
    input  wire ram_port_pkg::weight_addr_t update_weight_addr,
    word_stream_if.sink                   weight_stream,
    output logic                          weight_write_en,
    output ram_port_pkg::weight_addr_t    weight_write_addr,
    output ram_port_pkg::weight_row_t     weight_write_data
);
    import alexnet_layer_pkg::*;
    import ram_port_pkg::*;

    logic [$clog2(`KERNEL_TAPS)-1:0] tap_cnt;
    depth_t                          row_cnt;
    logic                            accept;
    logic                            row_full;
    logic                            last_row;

    assign accept   = weight_stream.valid && weight_stream.ready;
    assign row_full = tap_cnt == `KERNEL_TAPS - 1;
    assign last_row = row_cnt == kernel_depth(current_layer) - 1'b1;

    assign weight_stream.ready = weight_stream.busy && !weight_stream.finish;

    ////////////////////////////////////////
    // tap and row counting

    always_ff @(posedge clk or posedge pcieRst) begin
        if (pcieRst) begin
            tap_cnt              <= '0;
            row_cnt              <= '0;
            weight_write_en      <= 1'b0;
            weight_stream.finish <= 1'b0;
        end else begin
            weight_write_en <= accept && row_full;
            if (!weight_stream.busy) begin
                tap_cnt              <= '0;
                row_cnt              <= '0;
                weight_stream.finish <= 1'b0;
            end else if (accept) begin
                if (row_full) begin
                    tap_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                    if (last_row)
                        weight_stream.finish <= 1'b1;    // kernel complete
                end else begin
                    tap_cnt <= tap_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // row assembly

    // taps enter at the top, so the first word ends up lowest
    always_ff @(posedge clk) begin
        if (accept)
            weight_write_data <= {weight_stream.data,
                                  weight_write_data[$bits(weight_row_t)-1:`WORD_BITS]};
        if (accept && row_full)
            weight_write_addr <= update_weight_addr + weight_addr_t'(row_cnt);
    end

endmodule

`default_nettype wire

//--- hdl/word_stream_if.sv
`default_nettype none

interface word_stream_if;
    import ram_port_pkg::*;

    logic       valid;
    logic       ready;
    data_word_t data;
    logic       busy;      // job selected by the source
    logic       finish;    // sink has taken its last word

    modport source (output valid, output data, output busy, input ready, input finish);
    modport sink (input valid, input data, input busy, output ready, output finish);

endinterface

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module pcie_controller_tb -f filelist.f -o pcie_controller_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/pcie_controller_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- tests/pcie_controller_checker.sv
`default_nettype none

module pcie_controller_checker (
    input wire clk,
    input wire pcieRst,
    input wire update_weight,
    input wire update_bias,
    input wire pcie_data_ready,
    input wire update_weight_done,
    input wire update_bias_done,
    input wire layer_write_en,
    input wire weight_write_en,
    input wire bias_write_en
);

    int error_count = 0;    // failed assertions

    ////////////////////////////////////////
    // ram ports

    one_write_per_cycle: assert property (@(posedge clk) disable iff (pcieRst)
        $onehot0({layer_write_en, weight_write_en, bias_write_en}))
        else begin
            error_count++;
            $error("more than one RAM port written in a cycle");
        end

    ////////////////////////////////////////
    // status flags

    fm_ready_sticky: assert property (@(posedge clk) disable iff (pcieRst)
        pcie_data_ready |=> pcie_data_ready)
        else begin
            error_count++;
            $error("pcie_data_ready fell without a reset");
        end

    weight_done_needs_request: assert property (@(posedge clk) disable iff (pcieRst)
        update_weight_done |-> $past(update_weight))
        else begin
            error_count++;
            $error("update_weight_done high without a request");
        end

    bias_done_needs_request: assert property (@(posedge clk) disable iff (pcieRst)
        update_bias_done |-> $past(update_bias))
        else begin
            error_count++;
            $error("update_bias_done high without a request");
        end

endmodule

bind pcie_controller pcie_controller_checker u_pcie_controller_checker (
    .clk                (clk),
    .pcieRst            (pcieRst),
    .update_weight      (update_weight),
    .update_bias        (update_bias),
    .pcie_data_ready    (pcie_data_ready),
    .update_weight_done (update_weight_done),
    .update_bias_done   (update_bias_done),
    .layer_write_en     (layer_write_en),
    .weight_write_en    (weight_write_en),
    .bias_write_en      (bias_write_en)
);

`default_nettype wire

//--- tests/pcie_controller_tb.sv
`default_nettype none

`include "loader_settings.svh"

module pcie_controller_tb;
    import alexnet_layer_pkg::*;
    import ram_port_pkg::*;

    logic         clk = 1'b0;
    logic         pcieRst;
    layer_t       run_layer;
    logic         load_fm;
    logic         update_weight;
    weight_addr_t update_weight_addr;
    logic         update_bias;
    bias_addr_t   update_bias_addr;
    logic         host_valid;
    logic         host_ready;
    data_word_t   host_data;
    logic         pcie_data_ready;
    logic         update_weight_done;
    logic         update_bias_done;
    logic         layer_write_en;
    layer_addr_t  layer_write_addr;
    data_word_t   layer_write_data;
    logic         weight_write_en;
    weight_addr_t weight_write_addr;
    weight_row_t  weight_write_data;
    logic         bias_write_en;
    bias_addr_t   bias_write_addr;
    data_word_t   bias_write_data;

    byte          rec_kind[$];     // records as read from the file
    logic [15:0]  rec_arg[$];
    data_word_t   rec_word[$];
    data_word_t   grp_words[$];    // host words of the open group
    byte          grp_kind;
    logic [15:0]  grp_addr;
    layer_t       cur_layer = IDLE;

    // writes still owed by the DUT in order
    byte          exp_port[$];
    layer_addr_t  exp_addr[$];
    weight_row_t  exp_data[$];

    string        test_name = "reset";
    int           value_errors = 0;
    int           other_errors = 0;

    pcie_controller u_pcie_controller (.*);

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // helpers

    function automatic int depth_of(input layer_t layer);
        case (layer)
            CONV1:   return `CONV1_DEPTH;
            CONV2:   return `CONV2_DEPTH;
            CONV3:   return `CONV3_DEPTH;
            CONV4:   return `CONV4_DEPTH;
            CONV5:   return `CONV5_DEPTH;
            default: return 0;    // pool and fc
        endcase
    endfunction

    function automatic logic job_done();
        case (grp_kind)
            "F":     return pcie_data_ready;
            "W":     return update_weight_done;
            default: return update_bias_done;
        endcase
    endfunction

    task automatic note_failure(input string what);
        other_errors++;
        $display("%s in %s at time %0t", what, test_name, $time);
    endtask

    task automatic check_value(input string name, input weight_row_t expected,
                               input weight_row_t actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic expect_write(input byte port, input layer_addr_t addr,
                                input weight_row_t data);
        exp_port.push_back(port);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic set_request(input byte kind, input logic on);
        case (kind)
            "F":     load_fm = on;
            "W":     update_weight = on;
            default: update_bias = on;
        endcase
    endtask

    task automatic read_records();
        int          fd;
        string       line;
        byte         kind;
        logic [15:0] arg;
        data_word_t  word;
        fd = $fopen("tests/pcie_controller_tests.mem", "r");
        assert (fd != 0) else note_failure("could not open the test record file");
        if (fd == 0)
            return;
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] != "/"
                && $sscanf(line, "%c %h %h", kind, arg, word) == 3) begin
                rec_kind.push_back(kind);
                rec_arg.push_back(arg);
                rec_word.push_back(word);
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////
    // stimulus

    task automatic change_layer(input layer_t layer);
        @(posedge clk);
        #1;
        run_layer = layer;
        @(posedge clk);    // latched here
        @(negedge clk);
        assert (!update_weight_done && !update_bias_done)
            else note_failure("done flags not cleared by the layer change");
        cur_layer = layer;
    endtask

    task automatic send_words();
        int i;
        i = 0;
        while (i < grp_words.size()) begin
            @(posedge clk);
            #1;
            host_valid = ($urandom % 3) != 0;    // random gaps
            host_data  = grp_words[i];
            if (host_valid && host_ready)
                i++;    // taken on the next edge
        end
        @(posedge clk);
        #1;
        host_valid = 1'b0;
    endtask

    // all requests up while nothing may be accepted or written
    task automatic no_work_window();
        @(posedge clk);
        #1;
        load_fm       = 1'b1;
        update_weight = 1'b1;
        update_bias   = 1'b1;
        host_valid    = 1'b1;
        host_data     = grp_words[0];
        repeat (20) begin
            @(negedge clk);
            assert (!host_ready) else note_failure("host_ready raised in a layer without work");
        end
        @(posedge clk);
        #1;
        load_fm       = 1'b0;
        update_weight = 1'b0;
        update_bias   = 1'b0;
        host_valid    = 1'b0;
    endtask

    task automatic run_group(input logic keep);
        int          depth;
        int          r;
        int          t;
        logic        no_work;
        weight_row_t row;
        depth     = depth_of(cur_layer);
        test_name = $sformatf("%c_group_%s", grp_kind, cur_layer.name());
        no_work   = grp_kind == "F" ? cur_layer != IDLE : depth == 0;
        if (no_work) begin
            no_work_window();
            return;
        end
        case (grp_kind)
            "F": begin
                assert (grp_words.size() == `FM_WORDS)
                    else note_failure("feature map group has the wrong length");
                for (r = 0; r < grp_words.size(); r++)
                    expect_write("L", layer_addr_t'(r), weight_row_t'(grp_words[r]));
            end
            "W": begin
                assert (grp_words.size() == depth * `KERNEL_TAPS)
                    else note_failure("kernel group does not match the layer depth");
                for (r = 0; r < depth; r++) begin
                    row = '0;
                    for (t = 0; t < `KERNEL_TAPS; t++)
                        row[t*`WORD_BITS +: `WORD_BITS] = grp_words[r*`KERNEL_TAPS + t];
                    expect_write("W", layer_addr_t'(weight_addr_t'(grp_addr + r)), row);
                end
            end
            default: expect_write("B", layer_addr_t'(bias_addr_t'(grp_addr)),
                                  weight_row_t'(grp_words[0]));
        endcase
        @(posedge clk);
        #1;
        update_weight_addr = weight_addr_t'(grp_addr);
        update_bias_addr   = bias_addr_t'(grp_addr);
        set_request(grp_kind, 1'b1);
        send_words();
        @(negedge clk);
        while (!job_done())
            @(negedge clk);
        assert (exp_port.size() == 0) else note_failure("RAM writes missing at done");
        exp_port.delete();
        exp_addr.delete();
        exp_data.delete();
        if (!keep) begin
            @(posedge clk);
            #1;
            set_request(grp_kind, 1'b0);
            @(posedge clk);
            @(negedge clk);
            // feature map status stays while the done flags follow their request
            assert (job_done() == (grp_kind == "F"))
                else note_failure("status flag wrong after the request dropped");
        end
    endtask

    ////////////////////////////////////////
    // ram write monitor

    always @(negedge clk) begin
        byte         port;
        layer_addr_t addr;
        weight_row_t data;
        port = 0;
        if (layer_write_en) begin
            port = "L";
            addr = layer_write_addr;
            data = weight_row_t'(layer_write_data);
        end else if (weight_write_en) begin
            port = "W";
            addr = layer_addr_t'(weight_write_addr);
            data = weight_write_data;
        end else if (bias_write_en) begin
            port = "B";
            addr = layer_addr_t'(bias_write_addr);
            data = weight_row_t'(bias_write_data);
        end
        if (port != 0) begin
            assert (exp_port.size() != 0) else note_failure("RAM written with no write expected");
            if (exp_port.size() != 0) begin
                check_value({test_name, " port"}, weight_row_t'(exp_port.pop_front()),
                            weight_row_t'(port));
                check_value({test_name, " addr"}, weight_row_t'(exp_addr.pop_front()),
                            weight_row_t'(addr));
                check_value({test_name, " data"}, exp_data.pop_front(), data);
            end
        end
    end

    ////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        int i;
        int checker_errors;
        void'($urandom(67666));
        pcieRst            = 1'b1;
        run_layer          = IDLE;
        load_fm            = 1'b0;
        update_weight      = 1'b0;
        update_weight_addr = '0;
        update_bias        = 1'b0;
        update_bias_addr   = '0;
        host_valid         = 1'b0;
        host_data          = '0;
        read_records();
        repeat (10) @(posedge clk);
        #1;
        pcieRst = 1'b0;
        @(negedge clk);
        assert (!(layer_write_en || weight_write_en || bias_write_en || host_ready
                  || pcie_data_ready || update_weight_done || update_bias_done))
            else note_failure("outputs not cleared by reset");
        for (i = 0; i < rec_kind.size(); i++) begin
            case (rec_kind[i])
                "L": change_layer(layer_t'(rec_arg[i][3:0]));
                "G": begin
                    run_group(rec_arg[i][0]);
                    grp_words.delete();
                end
                default: begin
                    grp_kind = rec_kind[i];
                    grp_addr = rec_arg[i];
                    grp_words.push_back(rec_word[i]);
                end
            endcase
        end
        repeat (5) @(posedge clk);
        test_name = "final";
        assert (pcie_data_ready) else note_failure("pcie_data_ready did not stay high");
        checker_errors = u_pcie_controller.u_pcie_controller_checker.error_count;
        $display("error counts: %0d wrong values, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, checker_errors);
        if (value_errors == 0 && other_errors == 0 && checker_errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        #1;
        repeat (rec_kind.size() * 8 + 200) @(posedge clk);
        $display("watchdog expired, the DUT stopped answering during %s", test_name);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/pcie_controller_tests.mem
// kind arg word, hex: L layer, F fm word, W kernel base and tap, B bias address and word
// G ends a group, arg 1 keeps the request held afterwards
L 0 0000
F 0 1f03
F 0 2e14
F 0 3d25
F 0 4c36
F 0 5b47
F 0 6a58
F 0 7969
F 0 887a
F 0 978b
F 0 a69c
F 0 b5ad
F 0 c4be
F 0 d3cf
F 0 e2d0
F 0 f1e1
F 0 00f2
G 0 0000
L 1 0000
W 040 1101
W 040 1202
W 040 1303
W 040 1404
W 040 1505
W 040 1606
W 040 1707
W 040 1808
W 040 1909
W 040 2111
W 040 2212
W 040 2313
W 040 2414
W 040 2515
W 040 2616
W 040 2717
W 040 2818
W 040 2919
W 040 3121
W 040 3222
W 040 3323
W 040 3424
W 040 3525
W 040 3626
W 040 3727
W 040 3828
W 040 3929
G 1 0000
L 3 0000
W 1f0 8a01
W 1f0 8a02
W 1f0 8a03
W 1f0 8a04
W 1f0 8a05
W 1f0 8a06
W 1f0 8a07
W 1f0 8a08
W 1f0 8a09
W 1f0 9b11
W 1f0 9b12
W 1f0 9b13
W 1f0 9b14
W 1f0 9b15
W 1f0 9b16
W 1f0 9b17
W 1f0 9b18
W 1f0 9b19
G 0 0000
B 0a5 beef
G 0 0000
L 2 0000
W 020 dead
B 011 cafe
G 0 0000
